// File: compile.f
logic/raycast_pkg.sv
logic/ray_sequencer.sv
logic/ray_setup.sv
logic/sphere_quadratic.sv
logic/root_extract.sv
logic/closest_hit.sv
logic/raycaster_top.sv
verification/raycaster_props.sv
verification/raycaster_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= raycaster_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/raycaster_tb.sv
module raycaster_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RANDOM = 20;
    // rays that take a full sweep, directed ones plus the random ones
    localparam int NUM_RAYS = 9 + NUM_RANDOM;
    localparam longint WATCHDOG_NS = (NUM_RAYS + 4) * raycast_pkg::RAY_LATENCY * 8;

    logic                                 clk;
    logic                                 rst;
    logic                                 ray_valid;
    raycast_pkg::ray_t                    ray;
    raycast_pkg::shape_t                  shape;
    logic [raycast_pkg::ADDR_W-1:0]       shape_addr;
    logic                                 busy;
    logic                                 done;
    logic                                 hit;
    logic [raycast_pkg::ADDR_W-1:0]       hit_addr;
    logic signed [raycast_pkg::DOT_W-1:0] t_num;

    // shape memory model
    raycast_pkg::shape_t            scene [raycast_pkg::NUM_SHAPES];
    logic [raycast_pkg::ADDR_W-1:0] mem_addr_q;

    int     errors;
    int     checks;
    integer seed;

    raycaster_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .ray_valid_i  (ray_valid),
        .ray_i        (ray),
        .shape_i      (shape),
        .shape_addr_o (shape_addr),
        .busy_o       (busy),
        .done_o       (done),
        .hit_o        (hit),
        .hit_addr_o   (hit_addr),
        .t_num_o      (t_num)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // address seen in one cycle, data driven in the next
    always @(negedge clk) begin
        mem_addr_q = shape_addr;
    end

    always @(posedge clk) begin
        #1;
        shape = scene[mem_addr_q];
    end

    function automatic longint floor_sqrt(input longint v);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = longint'(1) << 27;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= v) begin
                lo = mid;
            end else begin
                hi = mid - 1;
            end
        end
        return lo;
    endfunction

    // nearer root numerator per sphere, smallest positive one wins
    function automatic void expect_ray(input raycast_pkg::ray_t r, output logic exp_hit,
                                       output int exp_addr, output longint exp_t);
        longint rel [3];
        longint dir [3];
        longint a;
        longint b;
        longint c;
        longint disc;
        longint t;
        exp_hit = 1'b0;
        exp_addr = 0;
        exp_t = 0;
        dir[0] = r.dir.x;
        dir[1] = r.dir.y;
        dir[2] = r.dir.z;
        for (int i = 0; i < raycast_pkg::NUM_SHAPES; i++) begin
            rel[0] = longint'(r.src.x) - longint'(scene[i].center.x);
            rel[1] = longint'(r.src.y) - longint'(scene[i].center.y);
            rel[2] = longint'(r.src.z) - longint'(scene[i].center.z);
            a = dir[0] * dir[0] + dir[1] * dir[1] + dir[2] * dir[2];
            b = rel[0] * dir[0] + rel[1] * dir[1] + rel[2] * dir[2];
            c = rel[0] * rel[0] + rel[1] * rel[1] + rel[2] * rel[2]
                - longint'(scene[i].radius_sq);
            disc = b * b - a * c;
            if (scene[i].active && disc >= 0) begin
                t = -b - floor_sqrt(disc);
                if (t > 0 && (!exp_hit || t < exp_t)) begin
                    exp_hit = 1'b1;
                    exp_addr = i;
                    exp_t = t;
                end
            end
        end
    endfunction

    function automatic raycast_pkg::shape_t make_shape(input logic active, input int x,
                                                       input int y, input int z,
                                                       input int rsq);
        raycast_pkg::shape_t s;
        s.active = active;
        s.center.x = raycast_pkg::COORD_W'(x);
        s.center.y = raycast_pkg::COORD_W'(y);
        s.center.z = raycast_pkg::COORD_W'(z);
        s.radius_sq = raycast_pkg::RSQ_W'(rsq);
        return s;
    endfunction

    function automatic raycast_pkg::ray_t make_ray(input int sx, input int sy, input int sz,
                                                   input int dx, input int dy, input int dz);
        raycast_pkg::ray_t r;
        r.src.x = raycast_pkg::COORD_W'(sx);
        r.src.y = raycast_pkg::COORD_W'(sy);
        r.src.z = raycast_pkg::COORD_W'(sz);
        r.dir.x = raycast_pkg::COORD_W'(dx);
        r.dir.y = raycast_pkg::COORD_W'(dy);
        r.dir.z = raycast_pkg::COORD_W'(dz);
        return r;
    endfunction

    task automatic clear_scene();
        for (int i = 0; i < raycast_pkg::NUM_SHAPES; i++) begin
            scene[i] = '0;
        end
    endtask

    // spheres strung along +x, one of them just off the axis
    task automatic load_line_scene();
        clear_scene();
        scene[1] = make_shape(1'b1, 300, 0, 0, 2500);
        scene[3] = make_shape(1'b1, 150, 0, 0, 2500);
        scene[6] = make_shape(1'b1, 120, 40, 0, 100);
    endtask

    // the next rising edge after the strobe accepts the ray
    task automatic strobe_ray(input raycast_pkg::ray_t r);
        @(posedge clk);
        #1;
        ray_valid = 1'b1;
        ray = r;
        @(posedge clk);
        #1;
        ray_valid = 1'b0;
    endtask

    task automatic wait_for_done(input string name, output int cycles);
        logic seen;
        logic busy_ok;
        cycles = 0;
        seen = 1'b0;
        busy_ok = 1'b1;
        while (!seen && cycles < 2 * raycast_pkg::RAY_LATENCY) begin
            @(posedge clk);
            #2;
            cycles++;
            busy_ok = busy_ok && busy;
            seen = done;
        end
        checks++;
        if (!seen) begin
            errors++;
            $display("%s: no done pulse within %0d cycles", name, cycles);
        end else if (cycles != raycast_pkg::RAY_LATENCY) begin
            errors++;
            $display("FAILED at %0d ns: %s done_o after %0d cycles, expected %0d",
                     $time, name, cycles, raycast_pkg::RAY_LATENCY);
        end
        if (!busy_ok) begin
            errors++;
            $display("FAILED at %0d ns: %s busy_o went low before the done pulse",
                     $time, name);
        end
    endtask

    task automatic compare_outputs(input string name, input logic exp_hit,
                                   input int exp_addr, input longint exp_t);
        checks++;
        if (hit !== exp_hit || hit_addr !== raycast_pkg::ADDR_W'(exp_addr)
            || t_num !== raycast_pkg::DOT_W'(exp_t)) begin
            errors++;
            $display("FAILED at %0d ns: %s gave hit %b addr %0d t_num %0d, expected %b %0d %0d",
                     $time, name, hit, hit_addr, t_num, exp_hit, exp_addr, exp_t);
        end
    endtask

    task automatic run_ray(input string name, input raycast_pkg::ray_t r);
        logic   exp_hit;
        int     exp_addr;
        longint exp_t;
        int     cycles;
        expect_ray(r, exp_hit, exp_addr, exp_t);
        strobe_ray(r);
        wait_for_done(name, cycles);
        compare_outputs(name, exp_hit, exp_addr, exp_t);
    endtask

    task automatic hit_single_sphere();
        $display("test: single sphere");
        clear_scene();
        scene[5] = make_shape(1'b1, 0, 0, 100, 400);
        run_ray("single sphere", make_ray(0, 0, 0, 0, 0, 1));
        compare_outputs("single sphere by hand", 1'b1, 5, 80);
        // t_num scales with |dir|^2
        run_ray("single sphere, long dir", make_ray(0, 0, 0, 0, 0, 3));
        compare_outputs("single sphere, long dir by hand", 1'b1, 5, 240);
    endtask

    task automatic pick_closest_sphere();
        $display("test: closest sphere");
        load_line_scene();
        run_ray("closest of three", make_ray(0, 0, 0, 2, 0, 0));
        compare_outputs("closest of three by hand", 1'b1, 3, 200);
        clear_scene();
        scene[2] = make_shape(1'b1, 400, 0, 0, 400);
        scene[5] = make_shape(1'b1, 600, 0, 0, 400);
        scene[6] = make_shape(1'b1, 400, 0, 0, 400);
        run_ray("equal spheres", make_ray(0, 0, 0, 2, 0, 0));
        compare_outputs("equal spheres by hand", 1'b1, 2, 760);
    endtask

    task automatic report_misses();
        $display("test: misses and inactive shapes");
        // off axis, behind the origin, around the origin
        clear_scene();
        scene[0] = make_shape(1'b1, 300, 300, 100, 900);
        scene[2] = make_shape(1'b1, 100, -100, 100, 2500);
        scene[5] = make_shape(1'b1, 100, 120, 100, 10000);
        run_ray("no sphere ahead", make_ray(100, 100, 100, 0, 1, 0));
        compare_outputs("no sphere ahead by hand", 1'b0, 0, 0);
        clear_scene();
        scene[0] = make_shape(1'b0, 100, 200, 100, 400);
        scene[4] = make_shape(1'b1, 100, 400, 100, 400);
        scene[7] = make_shape(1'b0, 100, 150, 100, 400);
        run_ray("inactive in path", make_ray(100, 100, 100, 0, 1, 0));
        compare_outputs("inactive in path by hand", 1'b1, 4, 280);
        scene[4].active = 1'b0;
        run_ray("all inactive", make_ray(100, 100, 100, 0, 1, 0));
        compare_outputs("all inactive by hand", 1'b0, 0, 0);
    endtask

    task automatic ignore_busy_strobe();
        raycast_pkg::ray_t first;
        raycast_pkg::ray_t second;
        logic              exp_hit;
        int                exp_addr;
        longint            exp_t;
        int                cycles;
        $display("test: strobe while busy");
        load_line_scene();
        first = make_ray(0, 0, 0, 2, 0, 0);
        second = make_ray(0, 0, 0, -2, 0, 0);
        expect_ray(first, exp_hit, exp_addr, exp_t);
        strobe_ray(first);
        fork
            begin
                // one strobe early in the sweep, one while hits are folded
                strobe_ray(second);
                repeat (37) @(posedge clk);
                strobe_ray(second);
            end
            wait_for_done("busy strobe, first ray", cycles);
        join
        compare_outputs("busy strobe, first ray", exp_hit, exp_addr, exp_t);
        compare_outputs("busy strobe, first ray by hand", 1'b1, 3, 200);
        @(posedge clk);
        #2;
        checks++;
        if (busy) begin
            errors++;
            $display("FAILED at %0d ns: busy_o still high after the done pulse", $time);
        end
        run_ray("ray after busy strobe", second);
        compare_outputs("ray after busy strobe by hand", 1'b0, 0, 0);
    endtask

    function automatic raycast_pkg::ray_t random_ray();
        raycast_pkg::ray_t r;
        r.src.x = raycast_pkg::COORD_W'($random(seed) % 200);
        r.src.y = raycast_pkg::COORD_W'($random(seed) % 200);
        r.src.z = raycast_pkg::COORD_W'($random(seed) % 200);
        r.dir.x = raycast_pkg::COORD_W'($random(seed) % 40);
        r.dir.y = raycast_pkg::COORD_W'($random(seed) % 40);
        r.dir.z = raycast_pkg::COORD_W'($random(seed) % 40);
        if (r.dir == '0) begin
            r.dir.x = 1;
        end
        return r;
    endfunction

    // centers scattered near the ray so that some spheres are hit
    task automatic load_random_scene(input raycast_pkg::ray_t r);
        int k;
        int rad;
        for (int i = 0; i < raycast_pkg::NUM_SHAPES; i++) begin
            k = {$random(seed)} % 16;
            rad = {$random(seed)} % 120;
            scene[i].active = ({$random(seed)} % 4) != 0;
            scene[i].center.x = raycast_pkg::COORD_W'(r.src.x + k * r.dir.x + $random(seed) % 60);
            scene[i].center.y = raycast_pkg::COORD_W'(r.src.y + k * r.dir.y + $random(seed) % 60);
            scene[i].center.z = raycast_pkg::COORD_W'(r.src.z + k * r.dir.z + $random(seed) % 60);
            scene[i].radius_sq = raycast_pkg::RSQ_W'(rad * rad);
        end
    endtask

    task automatic sweep_random_scenes();
        raycast_pkg::ray_t r;
        $display("test: random scenes");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = random_ray();
            load_random_scene(r);
            run_ray($sformatf("random ray %0d", n), r);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        seed = 32'hf48c;
        rst = 1'b1;
        ray_valid = 1'b0;
        ray = '0;
        shape = '0;
        mem_addr_q = '0;
        clear_scene();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        checks++;
        if (busy !== 1'b0 || done !== 1'b0 || shape_addr !== '0) begin
            errors++;
            $display("FAILED at %0d ns: outputs not idle after reset", $time);
        end
        hit_single_sphere();
        pick_closest_sphere();
        report_misses();
        ignore_busy_strobe();
        sweep_random_scenes();
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verification/raycaster_props.sv
module raycaster_props (
    input logic                           clk,
    input logic                           rst,
    input logic                           busy_i,
    input logic                           done_i,
    input logic [raycast_pkg::ADDR_W-1:0] shape_addr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // failures per property, summed for the testbench
    int n_pulse = 0;
    int n_busy = 0;
    int n_reset = 0;
    int n_addr = 0;
    int fail_count;

    assign fail_count = n_pulse + n_busy + n_reset + n_addr;

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
    else begin
        n_pulse++;
        $error("done_o high for two cycles in a row");
    end

    a_done_busy: assert property (@(posedge clk) disable iff (rst) done_i |-> busy_i)
    else begin
        n_busy++;
        $error("done_o high while busy_o is low");
    end

    // outputs idle right after reset
    a_reset_idle: assert property (@(posedge clk) rst |=> (!busy_i && !done_i))
    else begin
        n_reset++;
        $error("busy_o or done_o high in the cycle after reset");
    end

    // address parks at zero outside a sweep
    a_addr_idle: assert property (@(posedge clk) disable iff (rst)
        !busy_i |-> (shape_addr_i == '0))
    else begin
        n_addr++;
        $error("shape_addr_o not zero while idle");
    end

endmodule

bind raycaster_top raycaster_props u_props (
    .clk          (clk),
    .rst          (rst),
    .busy_i       (busy_o),
    .done_i       (done_o),
    .shape_addr_i (shape_addr_o)
);

// File: logic/raycaster_top.sv
module raycaster_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 ray_valid_i,
    input  raycast_pkg::ray_t                    ray_i,
    input  raycast_pkg::shape_t                  shape_i,
    output logic [raycast_pkg::ADDR_W-1:0]       shape_addr_o,
    output logic                                 busy_o,
    output logic                                 done_o,
    output logic                                 hit_o,
    output logic [raycast_pkg::ADDR_W-1:0]       hit_addr_o,
    output logic signed [raycast_pkg::DOT_W-1:0] t_num_o
);

    logic                           accept;
    raycast_pkg::ray_t              ray_held;
    logic                           issue_valid;
    logic [raycast_pkg::ADDR_W-1:0] issue_addr;
    logic                           issue_last;
    raycast_pkg::setup_t            setup_item;
    logic                           setup_last;
    raycast_pkg::quad_t             quad_item;
    logic                           quad_last;
    raycast_pkg::hit_t              root_result;
    logic                           root_last;

    // a strobe while busy is dropped
    assign accept = ray_valid_i && !busy_o;

    ray_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .ray_valid_i   (ray_valid_i),
        .ray_i         (ray_i),
        .ray_o         (ray_held),
        .shape_addr_o  (shape_addr_o),
        .issue_valid_o (issue_valid),
        .issue_addr_o  (issue_addr),
        .issue_last_o  (issue_last),
        .done_i        (done_o),
        .busy_o        (busy_o)
    );

    ray_setup u_setup (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .issue_addr_i  (issue_addr),
        .issue_last_i  (issue_last),
        .ray_i         (ray_held),
        .shape_i       (shape_i),
        .item_o        (setup_item),
        .last_o        (setup_last)
    );

    sphere_quadratic u_quad (
        .clk    (clk),
        .rst    (rst),
        .item_i (setup_item),
        .last_i (setup_last),
        .item_o (quad_item),
        .last_o (quad_last)
    );

    root_extract u_root (
        .clk      (clk),
        .rst      (rst),
        .item_i   (quad_item),
        .last_i   (quad_last),
        .result_o (root_result),
        .last_o   (root_last)
    );

    closest_hit u_best (
        .clk        (clk),
        .rst        (rst),
        .start_i    (accept),
        .result_i   (root_result),
        .last_i     (root_last),
        .done_o     (done_o),
        .hit_o      (hit_o),
        .hit_addr_o (hit_addr_o),
        .t_num_o    (t_num_o)
    );

endmodule

// File: logic/closest_hit.sv
module closest_hit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_i,
    input  raycast_pkg::hit_t                    result_i,
    input  logic                                 last_i,
    output logic                                 done_o,
    output logic                                 hit_o,
    output logic [raycast_pkg::ADDR_W-1:0]       hit_addr_o,
    output logic signed [raycast_pkg::DOT_W-1:0] t_num_o
);

    raycast_pkg::hit_t in_q;
    logic              in_last_q;
    logic              fin_q;
    logic              take;

    // best entry of the running sweep
    logic                                 best_hit;
    logic [raycast_pkg::ADDR_W-1:0]       best_addr;
    logic signed [raycast_pkg::DOT_W-1:0] best_t;

    // strict compare, so on a tie the earlier and lower address stays
    assign take = in_q.valid && in_q.hit && (!best_hit || (in_q.t_num < best_t));

    always_ff @(posedge clk) begin
        in_q <= result_i;
        if (take) begin
            best_addr <= in_q.addr;
            best_t    <= in_q.t_num;
        end
        if (rst) begin
            in_q.valid <= 1'b0;
            in_last_q  <= 1'b0;
            fin_q      <= 1'b0;
            done_o     <= 1'b0;
            best_hit   <= 1'b0;
        end else begin
            in_last_q <= last_i && result_i.valid;
            // set once the last item has been folded into the best entry
            fin_q     <= in_last_q;
            done_o    <= fin_q;
            if (start_i) begin
                best_hit <= 1'b0;
            end else if (take) begin
                best_hit <= 1'b1;
            end
        end
    end

    assign hit_o      = best_hit;
    // zero when nothing was hit
    assign hit_addr_o = best_hit ? best_addr : '0;
    assign t_num_o    = best_hit ? best_t : '0;

endmodule

// File: logic/root_extract.sv
module root_extract (
    input  logic               clk,
    input  logic               rst,
    input  raycast_pkg::quad_t item_i,
    input  logic               last_i,
    output raycast_pkg::hit_t  result_o,
    output logic               last_o
);

    // remainder, partial root and the radicand bits still to bring down
    logic [raycast_pkg::ROOT_W-1:0] rem_q  [raycast_pkg::ROOT_STAGES];
    logic [raycast_pkg::ROOT_W-1:0] root_q [raycast_pkg::ROOT_STAGES+1];
    logic [raycast_pkg::DISC_W-1:0] rad_q  [raycast_pkg::ROOT_STAGES];

    // item fields riding along with the root
    logic [raycast_pkg::ROOT_STAGES-1:0] vld_sr;
    logic [raycast_pkg::ROOT_STAGES-1:0] last_sr;
    logic [raycast_pkg::ROOT_STAGES-1:0] act_sr;
    logic [raycast_pkg::ROOT_STAGES-1:0] pos_sr;
    logic [raycast_pkg::ADDR_W-1:0]      addr_sr [raycast_pkg::ROOT_STAGES];
    logic signed [raycast_pkg::DOT_W-1:0] b_sr   [raycast_pkg::ROOT_STAGES];
    logic signed [raycast_pkg::DOT_W-1:0] t_calc;

    // negative discriminant runs on zero, hit is masked later
    assign rem_q[0]  = '0;
    assign root_q[0] = '0;
    assign rad_q[0]  = item_i.disc[raycast_pkg::DISC_W-1] ? '0 : item_i.disc;

    // restoring square root, one result bit per stage
    for (genvar i = 0; i < raycast_pkg::ROOT_STAGES; i++) begin : g_stage
        logic [raycast_pkg::ROOT_W+1:0] cur;
        logic [raycast_pkg::ROOT_W+1:0] trial;
        logic                           take;

        assign cur   = {rem_q[i], rad_q[i][raycast_pkg::DISC_W-1 -: 2]};
        assign trial = {root_q[i], 2'b01};
        assign take  = (cur >= trial);

        always_ff @(posedge clk) begin
            root_q[i+1] <= {root_q[i][raycast_pkg::ROOT_W-2:0], take};
        end

        // final remainder is not needed
        if (i < raycast_pkg::ROOT_STAGES - 1) begin : g_carry
            logic [raycast_pkg::ROOT_W-1:0] diff;

            assign diff = raycast_pkg::ROOT_W'(cur - trial);

            always_ff @(posedge clk) begin
                rem_q[i+1] <= take ? diff : cur[raycast_pkg::ROOT_W-1:0];
                rad_q[i+1] <= {rad_q[i][raycast_pkg::DISC_W-3:0], 2'b00};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr  <= {vld_sr[raycast_pkg::ROOT_STAGES-2:0], item_i.valid};
            last_sr <= {last_sr[raycast_pkg::ROOT_STAGES-2:0], item_i.valid && last_i};
        end
    end

    always_ff @(posedge clk) begin
        act_sr     <= {act_sr[raycast_pkg::ROOT_STAGES-2:0], item_i.active};
        pos_sr     <= {pos_sr[raycast_pkg::ROOT_STAGES-2:0], !item_i.disc[raycast_pkg::DISC_W-1]};
        addr_sr[0] <= item_i.addr;
        b_sr[0]    <= item_i.b;
        for (int k = 1; k < raycast_pkg::ROOT_STAGES; k++) begin
            addr_sr[k] <= addr_sr[k-1];
            b_sr[k]    <= b_sr[k-1];
        end
    end

    // nearer root numerator, t times |dir|^2
    assign t_calc = -b_sr[raycast_pkg::ROOT_STAGES-1]
                    - $signed({1'b0, root_q[raycast_pkg::ROOT_STAGES]});

    always_ff @(posedge clk) begin
        result_o.addr  <= addr_sr[raycast_pkg::ROOT_STAGES-1];
        result_o.t_num <= t_calc;
        // only a root in front of the origin counts
        result_o.hit   <= act_sr[raycast_pkg::ROOT_STAGES-1]
                          && pos_sr[raycast_pkg::ROOT_STAGES-1] && (t_calc > 0);
        if (rst) begin
            result_o.valid <= 1'b0;
            last_o         <= 1'b0;
        end else begin
            result_o.valid <= vld_sr[raycast_pkg::ROOT_STAGES-1];
            last_o         <= last_sr[raycast_pkg::ROOT_STAGES-1];
        end
    end

endmodule

// File: logic/sphere_quadratic.sv
module sphere_quadratic (
    input  logic                clk,
    input  logic                rst,
    input  raycast_pkg::setup_t item_i,
    input  logic                last_i,
    output raycast_pkg::quad_t  item_o,
    output logic                last_o
);

    // item fields carried through stages 1 to 3
    logic [raycast_pkg::QUAD_LATENCY-2:0] vld_sr;
    logic [raycast_pkg::QUAD_LATENCY-2:0] last_sr;
    logic [raycast_pkg::QUAD_LATENCY-2:0] act_sr;
    logic [raycast_pkg::ADDR_W-1:0]       addr_sr [raycast_pkg::QUAD_LATENCY-1];

    // stage 1 products per axis
    logic signed [raycast_pkg::DOT_W-1:0] dd [3];
    logic signed [raycast_pkg::DOT_W-1:0] rd [3];
    logic signed [raycast_pkg::DOT_W-1:0] rr [3];
    logic [raycast_pkg::RSQ_W-1:0]        rsq_q;

    // stage 2 coefficients, half-b form
    logic signed [raycast_pkg::DOT_W-1:0] a_q;
    logic signed [raycast_pkg::DOT_W-1:0] b_q;
    logic signed [raycast_pkg::DOT_W-1:0] c_q;

    // stage 3
    logic signed [raycast_pkg::DISC_W-1:0] bb_q;
    logic signed [raycast_pkg::DISC_W-1:0] ac_q;
    logic signed [raycast_pkg::DOT_W-1:0]  b3_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr  <= {vld_sr[raycast_pkg::QUAD_LATENCY-3:0], item_i.valid};
            last_sr <= {last_sr[raycast_pkg::QUAD_LATENCY-3:0], item_i.valid && last_i};
        end
    end

    always_ff @(posedge clk) begin
        act_sr     <= {act_sr[raycast_pkg::QUAD_LATENCY-3:0], item_i.active};
        addr_sr[0] <= item_i.addr;
        for (int k = 1; k < raycast_pkg::QUAD_LATENCY - 1; k++) begin
            addr_sr[k] <= addr_sr[k-1];
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        dd[0] <= item_i.dir.x * item_i.dir.x;
        dd[1] <= item_i.dir.y * item_i.dir.y;
        dd[2] <= item_i.dir.z * item_i.dir.z;
        rd[0] <= item_i.rel.x * item_i.dir.x;
        rd[1] <= item_i.rel.y * item_i.dir.y;
        rd[2] <= item_i.rel.z * item_i.dir.z;
        rr[0] <= item_i.rel.x * item_i.rel.x;
        rr[1] <= item_i.rel.y * item_i.rel.y;
        rr[2] <= item_i.rel.z * item_i.rel.z;
        rsq_q <= item_i.radius_sq;
    end

    // stage 2: a = dir.dir, b = rel.dir, c = rel.rel - r^2
    always_ff @(posedge clk) begin
        a_q <= dd[0] + dd[1] + dd[2];
        b_q <= rd[0] + rd[1] + rd[2];
        c_q <= rr[0] + rr[1] + rr[2] - $signed({1'b0, rsq_q});
    end

    // stage 3
    always_ff @(posedge clk) begin
        bb_q <= b_q * b_q;
        ac_q <= a_q * c_q;
        b3_q <= b_q;
    end

    // stage 4: discriminant of the half-b quadratic
    always_ff @(posedge clk) begin
        item_o.addr   <= addr_sr[raycast_pkg::QUAD_LATENCY-2];
        item_o.active <= act_sr[raycast_pkg::QUAD_LATENCY-2];
        item_o.b      <= b3_q;
        item_o.disc   <= bb_q - ac_q;
        if (rst) begin
            item_o.valid <= 1'b0;
            last_o       <= 1'b0;
        end else begin
            item_o.valid <= vld_sr[raycast_pkg::QUAD_LATENCY-2];
            last_o       <= last_sr[raycast_pkg::QUAD_LATENCY-2];
        end
    end

endmodule

// File: logic/ray_setup.sv
module ray_setup (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           issue_valid_i,
    input  logic [raycast_pkg::ADDR_W-1:0] issue_addr_i,
    input  logic                           issue_last_i,
    input  raycast_pkg::ray_t              ray_i,
    input  raycast_pkg::shape_t            shape_i,
    output raycast_pkg::setup_t            item_o,
    output logic                           last_o
);

    // decode of the scene word against the held ray
    // inactive entries still go down the pipe so every sweep has NUM_SHAPES items
    always_ff @(posedge clk) begin
        item_o.addr   <= issue_addr_i;
        item_o.active <= shape_i.active;

        // origin moved into the sphere's frame
        item_o.rel.x <= ray_i.src.x - shape_i.center.x;
        item_o.rel.y <= ray_i.src.y - shape_i.center.y;
        item_o.rel.z <= ray_i.src.z - shape_i.center.z;

        item_o.dir       <= ray_i.dir;
        item_o.radius_sq <= shape_i.radius_sq;

        if (rst) begin
            item_o.valid <= 1'b0;
            last_o       <= 1'b0;
        end else begin
            item_o.valid <= issue_valid_i;
            // last marker only counts on a real item
            last_o       <= issue_valid_i && issue_last_i;
        end
    end

endmodule

// File: logic/ray_sequencer.sv
module ray_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ray_valid_i,
    input  raycast_pkg::ray_t              ray_i,
    output raycast_pkg::ray_t              ray_o,
    output logic [raycast_pkg::ADDR_W-1:0] shape_addr_o,
    output logic                           issue_valid_o,
    output logic [raycast_pkg::ADDR_W-1:0] issue_addr_o,
    output logic                           issue_last_o,
    input  logic                           done_i,
    output logic                           busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        SENDING,
        WAITING
    } state_t;

    state_t                         state;
    logic [raycast_pkg::ADDR_W-1:0] addr_q;
    logic                           at_last;
    raycast_pkg::ray_t              ray_q;

    assign at_last = (addr_q == raycast_pkg::ADDR_W'(raycast_pkg::NUM_SHAPES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            addr_q        <= '0;
            issue_valid_o <= 1'b0;
            issue_last_o  <= 1'b0;
        end else begin
            // memory answers a cycle after the address
            issue_valid_o <= (state == SENDING);
            issue_last_o  <= (state == SENDING) && at_last;
            case (state)
                IDLE: begin
                    if (ray_valid_i) begin
                        state <= SENDING;
                    end
                end
                SENDING: begin
                    if (at_last) begin
                        state  <= WAITING;
                        addr_q <= '0;
                    end else begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                WAITING: begin
                    // pipeline drains, result stage ends the ray
                    if (done_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ray held for the whole sweep
    always_ff @(posedge clk) begin
        issue_addr_o <= addr_q;
        if (state == IDLE && ray_valid_i) begin
            ray_q <= ray_i;
        end
    end

    assign ray_o        = ray_q;
    assign shape_addr_o = addr_q;
    assign busy_o       = (state != IDLE);

endmodule

// File: logic/raycast_pkg.sv
package raycast_pkg;

    // datapath widths
    localparam int COORD_W = 12;
    localparam int REL_W = COORD_W + 1;
    localparam int RSQ_W = 24;
    localparam int DOT_W = 28;
    localparam int DISC_W = 54;
    localparam int ROOT_W = 27;

    // scene memory
    localparam int NUM_SHAPES = 8;
    localparam int ADDR_W = 3;

    // cycle counts
    localparam int SETUP_LATENCY = 1;
    localparam int QUAD_LATENCY = 4;
    localparam int ROOT_STAGES = ROOT_W;
    localparam int PIPE_LATENCY = SETUP_LATENCY + QUAD_LATENCY + ROOT_STAGES + 1;
    // accepting edge to done_o
    localparam int RAY_LATENCY = NUM_SHAPES + PIPE_LATENCY + 3;

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic signed [COORD_W-1:0] z;
    } vec3_t;

    typedef struct packed {
        vec3_t src;
        vec3_t dir;
    } ray_t;

    // scene word as stored in shape memory
    typedef struct packed {
        logic              active;
        vec3_t             center;
        logic [RSQ_W-1:0]  radius_sq;
    } shape_t;

    // source minus center, one bit wider than a coordinate
    typedef struct packed {
        logic signed [REL_W-1:0] x;
        logic signed [REL_W-1:0] y;
        logic signed [REL_W-1:0] z;
    } rel_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic              active;
        rel_t              rel;
        vec3_t             dir;
        logic [RSQ_W-1:0]  radius_sq;
    } setup_t;

    typedef struct packed {
        logic                     valid;
        logic [ADDR_W-1:0]        addr;
        logic                     active;
        logic signed [DOT_W-1:0]  b;
        logic signed [DISC_W-1:0] disc;
    } quad_t;

    typedef struct packed {
        logic                    valid;
        logic [ADDR_W-1:0]       addr;
        logic                    hit;
        logic signed [DOT_W-1:0] t_num;
    } hit_t;

endpackage
